// File: front_end_settings.svh
//////////////////////////////
// front-end settings
// widths, bus region split, housekeeping map
// and the board id word
//////////////////////////////

`ifndef FRONT_END_SETTINGS_SVH
`define FRONT_END_SETTINGS_SVH

// datapath
`define FE_SAMPLE_W    14         // converter word
`define FE_SUM_W       15         // gen + feedback adder, one guard bit
`define FE_LSB_MASK_W  2          // adc lsbs forced to zero

// system bus
`define FE_SYS_AW      32
`define FE_SYS_DW      32
`define FE_REGION_W    20         // offset bits inside one region
`define FE_REGION_N    8          // regions on the bus
`define FE_HK_REGION   0          // housekeeping slot

// housekeeping map
`define FE_HK_ID_OFS   'h00
`define FE_HK_LOOP_OFS 'h04
`define FE_HK_LED_OFS  'h08
`define FE_HK_ID       32'h4146_0001  // read-only board id
`define FE_LED_W       8

`endif

// File: sample_pkg.sv
//////////////////////////////
// sample types
// adc samples, converter codes and the
// widened sum used ahead of the clamp
//////////////////////////////

`include "front_end_settings.svh"

package sample_pkg;

  //////////////////////////////
  // channel samples
  //////////////////////////////

  // two's complement, as seen by the scope side
  typedef logic signed [`FE_SAMPLE_W-1:0] adc_sample_t;

  //////////////////////////////
  // converter side
  //////////////////////////////

  // neg-slope code, straight to the dac pins
  typedef logic [`FE_SAMPLE_W-1:0] dac_code_t;

  // one extra bit so gen + feedback never wraps
  typedef logic signed [`FE_SUM_W-1:0] dac_sum_t;

endpackage : sample_pkg

// File: sys_bus_pkg.sv
//////////////////////////////
// system bus types
// address, data word, region index and
// in-region offset
//////////////////////////////

`include "front_end_settings.svh"

package sys_bus_pkg;

  typedef logic [`FE_SYS_AW-1:0] sys_addr_t;   // full byte address
  typedef logic [`FE_SYS_DW-1:0] sys_word_t;   // read/write data

  // region select, sits just above the offset bits
  typedef logic [$clog2(`FE_REGION_N)-1:0] sys_region_t;

  // offset inside a region
  typedef logic [`FE_REGION_W-1:0] hk_ofs_t;

endpackage : sys_bus_pkg

// File: adc_input_stage.sv
//////////////////////////////
// adc input stage
// crosses the two adc channels, clears
// the low bits and picks the loopback
// source, one register stage
//////////////////////////////

`include "front_end_settings.svh"

module adc_input_stage
  import sample_pkg::*;
(
  input  logic        adc_clk,
  input  logic        reset_i,
  input  adc_sample_t adc_dat_a_i,     // physical adc a
  input  adc_sample_t adc_dat_b_i,     // physical adc b
  input  dac_code_t   loop_code_a_i,   // dac code ch a, combinational
  input  dac_code_t   loop_code_b_i,   // dac code ch b, combinational
  input  logic        digital_loop_i,  // from housekeeping
  output adc_sample_t adc_ch_a_o,
  output adc_sample_t adc_ch_b_o
);

  adc_sample_t adc_a_msk;
  adc_sample_t adc_b_msk;

  // low bits carry only noise on this board
  assign adc_a_msk = {adc_dat_a_i[`FE_SAMPLE_W-1:`FE_LSB_MASK_W], {`FE_LSB_MASK_W{1'b0}}};
  assign adc_b_msk = {adc_dat_b_i[`FE_SAMPLE_W-1:`FE_LSB_MASK_W], {`FE_LSB_MASK_W{1'b0}}};

  //////////////////////////////
  // crossing + loopback select
  //////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      adc_ch_a_o <= '0;
      adc_ch_b_o <= '0;
    end
    else if (digital_loop_i)
    begin
      // each channel sees its own dac code
      adc_ch_a_o <= adc_sample_t'(loop_code_a_i);
      adc_ch_b_o <= adc_sample_t'(loop_code_b_i);
    end
    else
    begin
      adc_ch_a_o <= adc_b_msk;  // adc b -> ch a
      adc_ch_b_o <= adc_a_msk;  // adc a -> ch b
    end
  end

endmodule : adc_input_stage

// File: dac_output_stage.sv
//////////////////////////////
// dac output stage
// gen + feedback sum, clamp to 14 bit,
// neg-slope inversion, two register
// stages with channel swap, dac reset
//////////////////////////////

`include "front_end_settings.svh"

module dac_output_stage
  import sample_pkg::*;
(
  input  logic        adc_clk,
  input  logic        reset_i,
  input  adc_sample_t asg_a_i,        // generator ch a
  input  adc_sample_t asg_b_i,        // generator ch b
  input  adc_sample_t pid_a_i,        // feedback ch a
  input  adc_sample_t pid_b_i,        // feedback ch b
  output dac_code_t   loop_code_a_o,  // unregistered, for loopback
  output dac_code_t   loop_code_b_o,
  output dac_code_t   dac_dat_a_o,    // carries ch b
  output dac_code_t   dac_dat_b_o,    // carries ch a
  output logic        dac_reset_o
);

  dac_code_t code_a_q;
  dac_code_t code_b_q;

  //////////////////////////////
  // sum, clamp, invert
  //////////////////////////////

  // same rule for both channels
  function automatic dac_code_t neg_slope_code(input adc_sample_t gen,
                                               input adc_sample_t fbk);
    dac_sum_t    sum;
    adc_sample_t sat;
    sum = dac_sum_t'(gen) + dac_sum_t'(fbk);  // sign extended
    // top two bits differ -> outside 14-bit range
    if (sum[`FE_SUM_W-1] != sum[`FE_SUM_W-2])
      sat = {sum[`FE_SUM_W-1], {(`FE_SAMPLE_W-1){~sum[`FE_SUM_W-1]}}};
    else
      sat = sum[`FE_SAMPLE_W-1:0];
    // converter counts down as voltage rises
    return dac_code_t'(~sat);
  endfunction

  assign loop_code_a_o = neg_slope_code(asg_a_i, pid_a_i);
  assign loop_code_b_o = neg_slope_code(asg_b_i, pid_b_i);

  //////////////////////////////
  // output pipeline
  //////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      code_a_q    <= '0;
      code_b_q    <= '0;
      dac_dat_a_o <= '0;
      dac_dat_b_o <= '0;
    end
    else
    begin
      code_a_q    <= loop_code_a_o;  // stage 1
      code_b_q    <= loop_code_b_o;
      dac_dat_a_o <= code_b_q;       // ch b -> dac a
      dac_dat_b_o <= code_a_q;       // ch a -> dac b
    end
  end

  // converter held in reset one cycle behind the fabric
  always_ff @(posedge adc_clk)
  begin
    dac_reset_o <= reset_i;
  end

endmodule : dac_output_stage

// File: sys_bus_decoder.sv
//////////////////////////////
// system bus decoder
// splits the address into eight regions,
// routes housekeeping strobes and answers
// every other region with an error
//////////////////////////////

`include "front_end_settings.svh"

module sys_bus_decoder
  import sys_bus_pkg::*;
(
  input  logic      adc_clk,
  input  logic      reset_i,
  // bus master side
  input  sys_addr_t sys_addr_i,
  input  sys_word_t sys_wdata_i,
  input  logic      sys_wen_i,
  input  logic      sys_ren_i,
  output sys_word_t sys_rdata_o,
  output logic      sys_err_o,
  output logic      sys_ack_o,
  // housekeeping side
  output hk_ofs_t   hk_ofs_o,
  output sys_word_t hk_wdata_o,
  output logic      hk_wen_o,
  output logic      hk_ren_o,
  input  sys_word_t hk_rdata_i,
  input  logic      hk_ack_i,
  input  logic      hk_err_i
);

  sys_region_t region;
  logic        hk_hit;
  logic        miss_ack_q;   // reply for unmapped regions

  //////////////////////////////
  // address split
  //////////////////////////////

  assign region   = sys_addr_i[`FE_REGION_W +: $bits(sys_region_t)];
  assign hk_hit   = (region == sys_region_t'(`FE_HK_REGION));
  assign hk_ofs_o = sys_addr_i[`FE_REGION_W-1:0];  // offset check left to hk_regs

  // strobes only reach housekeeping on a hit
  assign hk_wdata_o = sys_wdata_i;
  assign hk_wen_o   = sys_wen_i & hk_hit;
  assign hk_ren_o   = sys_ren_i & hk_hit;

  // other seven regions: ack with err next cycle
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      miss_ack_q <= 1'b0;
    else
      miss_ack_q <= (sys_wen_i | sys_ren_i) & ~hk_hit;
  end

  //////////////////////////////
  // reply mux
  //////////////////////////////

  assign sys_ack_o   = hk_ack_i | miss_ack_q;
  assign sys_err_o   = hk_err_i | miss_ack_q;
  assign sys_rdata_o = hk_ack_i ? hk_rdata_i : '0;  // zero on miss

endmodule : sys_bus_decoder

// File: hk_regs.sv
//////////////////////////////
// housekeeping registers
// id word, loopback enable and led byte,
// ack one cycle after the strobe
//////////////////////////////

`include "front_end_settings.svh"

module hk_regs
  import sys_bus_pkg::*;
(
  input  logic                 adc_clk,
  input  logic                 reset_i,
  input  hk_ofs_t              hk_ofs_i,
  input  sys_word_t            hk_wdata_i,
  input  logic                 hk_wen_i,
  input  logic                 hk_ren_i,
  output sys_word_t            hk_rdata_o,
  output logic                 hk_ack_o,
  output logic                 hk_err_o,
  output logic                 digital_loop_o,  // adc takes dac codes
  output logic [`FE_LED_W-1:0] led_o
);

  sys_word_t rd_val;    // read mux
  logic      ofs_bad;   // offset not in the map
  logic      id_wr;     // id is read only

  //////////////////////////////
  // offset decode
  //////////////////////////////

  always_comb
  begin
    rd_val  = '0;
    ofs_bad = 1'b0;
    case (hk_ofs_i)
      `FE_HK_ID_OFS:   rd_val = `FE_HK_ID;
      `FE_HK_LOOP_OFS: rd_val = sys_word_t'(digital_loop_o);
      `FE_HK_LED_OFS:  rd_val = sys_word_t'(led_o);
      default:         ofs_bad = 1'b1;
    endcase
  end

  assign id_wr = hk_wen_i & (hk_ofs_i == hk_ofs_t'(`FE_HK_ID_OFS));

  //////////////////////////////
  // registers and reply
  //////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      digital_loop_o <= 1'b0;
      led_o          <= '0;
      hk_ack_o       <= 1'b0;
      hk_err_o       <= 1'b0;
      hk_rdata_o     <= '0;
    end
    else
    begin
      if (hk_wen_i && hk_ofs_i == hk_ofs_t'(`FE_HK_LOOP_OFS))
        digital_loop_o <= hk_wdata_i[0];
      if (hk_wen_i && hk_ofs_i == hk_ofs_t'(`FE_HK_LED_OFS))
        led_o <= hk_wdata_i[`FE_LED_W-1:0];
      hk_ack_o   <= hk_wen_i | hk_ren_i;
      hk_err_o   <= (hk_wen_i | hk_ren_i) & (ofs_bad | id_wr);
      // read data only on a good read, else zero
      hk_rdata_o <= (hk_ren_i & ~ofs_bad) ? rd_val : '0;
    end
  end

endmodule : hk_regs

// File: analog_front_top.sv
//////////////////////////////
// analog front-end top
// adc input, dac output, bus decoder
// and housekeeping on adc_clk
//////////////////////////////

`include "front_end_settings.svh"

module analog_front_top
  import sample_pkg::*;
  import sys_bus_pkg::*;
(
  input  logic                 adc_clk,
  input  logic                 reset_i,
  // converters and stream samples
  input  adc_sample_t          adc_dat_a_i,
  input  adc_sample_t          adc_dat_b_i,
  input  adc_sample_t          asg_a_i,
  input  adc_sample_t          asg_b_i,
  input  adc_sample_t          pid_a_i,
  input  adc_sample_t          pid_b_i,
  output adc_sample_t          adc_ch_a_o,
  output adc_sample_t          adc_ch_b_o,
  output dac_code_t            dac_dat_a_o,
  output dac_code_t            dac_dat_b_o,
  output logic                 dac_reset_o,
  // system bus
  input  sys_addr_t            sys_addr_i,
  input  sys_word_t            sys_wdata_i,
  input  logic                 sys_wen_i,
  input  logic                 sys_ren_i,
  output sys_word_t            sys_rdata_o,
  output logic                 sys_err_o,
  output logic                 sys_ack_o,
  output logic [`FE_LED_W-1:0] led_o
);

  //////////////////////////////
  // local signals
  //////////////////////////////

  logic      digital_loop;
  dac_code_t loop_code_a, loop_code_b;   // combinational dac codes
  hk_ofs_t   hk_ofs;
  sys_word_t hk_wdata, hk_rdata;
  logic      hk_wen, hk_ren, hk_ack, hk_err;

  adc_input_stage adc_in (
    .adc_clk        (adc_clk),
    .reset_i        (reset_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .loop_code_a_i  (loop_code_a),
    .loop_code_b_i  (loop_code_b),
    .digital_loop_i (digital_loop),
    .adc_ch_a_o     (adc_ch_a_o),
    .adc_ch_b_o     (adc_ch_b_o)
  );

  dac_output_stage dac_out (
    .adc_clk       (adc_clk),
    .reset_i       (reset_i),
    .asg_a_i       (asg_a_i),
    .asg_b_i       (asg_b_i),
    .pid_a_i       (pid_a_i),
    .pid_b_i       (pid_b_i),
    .loop_code_a_o (loop_code_a),
    .loop_code_b_o (loop_code_b),
    .dac_dat_a_o   (dac_dat_a_o),
    .dac_dat_b_o   (dac_dat_b_o),
    .dac_reset_o   (dac_reset_o)
  );

  sys_bus_decoder bus_dec (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_err_o   (sys_err_o),
    .sys_ack_o   (sys_ack_o),
    .hk_ofs_o    (hk_ofs),
    .hk_wdata_o  (hk_wdata),
    .hk_wen_o    (hk_wen),
    .hk_ren_o    (hk_ren),
    .hk_rdata_i  (hk_rdata),
    .hk_ack_i    (hk_ack),
    .hk_err_i    (hk_err)
  );

  hk_regs hk (
    .adc_clk        (adc_clk),
    .reset_i        (reset_i),
    .hk_ofs_i       (hk_ofs),
    .hk_wdata_i     (hk_wdata),
    .hk_wen_i       (hk_wen),
    .hk_ren_i       (hk_ren),
    .hk_rdata_o     (hk_rdata),
    .hk_ack_o       (hk_ack),
    .hk_err_o       (hk_err),
    .digital_loop_o (digital_loop),
    .led_o          (led_o)
  );

endmodule : analog_front_top

// File: tb_clock_gen.sv
//////////////////////////////
// testbench clock and reset
// adc_clk at period 8, reset held
// for two rising edges
//////////////////////////////

module tb_clock_gen
(
  output logic adc_clk,
  output logic reset_i
);

  initial
  begin
    adc_clk = 1'b0;
    forever #4 adc_clk = ~adc_clk;
  end

  initial
  begin
    reset_i = 1'b1;
    repeat (2) @(posedge adc_clk);
    @(negedge adc_clk);  // release on the falling edge
    reset_i = 1'b0;
  end

endmodule : tb_clock_gen

// File: analog_front_tb.sv
//////////////////////////////
// analog front-end testbench
// table of sample and bus entries,
// expected values from the datapath rules
//////////////////////////////

`include "front_end_settings.svh"

module analog_front_tb
  import sample_pkg::*;
  import sys_bus_pkg::*;
();

  localparam int MAX_S = (1 << (`FE_SAMPLE_W-1)) - 1;  // +8191
  localparam int MIN_S = -(1 << (`FE_SAMPLE_W-1));     // -8192

  typedef struct packed {
    logic        is_bus;
    logic        wr;
    adc_sample_t adc_a, adc_b;
    adc_sample_t asg_a, asg_b;
    adc_sample_t pid_a, pid_b;
    sys_addr_t   addr;
    sys_word_t   wdata, exp_rdata;
    logic        exp_err;
  } entry_t;

  logic adc_clk, reset_i;
  adc_sample_t adc_dat_a_i, adc_dat_b_i, asg_a_i, asg_b_i, pid_a_i, pid_b_i;
  adc_sample_t adc_ch_a_o, adc_ch_b_o;
  dac_code_t dac_dat_a_o, dac_dat_b_o;
  logic dac_reset_o;
  sys_addr_t sys_addr_i;
  sys_word_t sys_wdata_i, sys_rdata_o;
  logic sys_wen_i, sys_ren_i, sys_err_o, sys_ack_o;
  logic [`FE_LED_W-1:0] led_o;

  entry_t table_q[$];
  int seed = 32'h359e_df93;
  int checks = 0;
  int errors = 0;
  int cycles = 0;
  int limit = 0;
  logic loop_model = 1'b0;              // expected loopback state
  logic [`FE_LED_W-1:0] led_model = '0;
  entry_t last_smp = '0;                // samples still in the dac pipe

  tb_clock_gen clk_gen (.adc_clk(adc_clk), .reset_i(reset_i));

  analog_front_top dut0 (.*);

  //////////////////////////////
  // expected values
  //////////////////////////////

  function automatic dac_code_t expect_code(input adc_sample_t gen, input adc_sample_t fbk);
    int s;
    s = int'(gen) + int'(fbk);
    if (s > MAX_S)
      s = MAX_S;
    else if (s < MIN_S)
      s = MIN_S;
    return dac_code_t'(~s);  // neg-slope code in the low 14 bits
  endfunction

  function automatic adc_sample_t expect_adc(input adc_sample_t w);
    return (w >>> `FE_LSB_MASK_W) <<< `FE_LSB_MASK_W;
  endfunction

  function automatic adc_sample_t random_sample();
    return adc_sample_t'($random(seed));
  endfunction

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic check_sample(input string name, input adc_sample_t got, input adc_sample_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_code(input string name, input dac_code_t got, input dac_code_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input sys_word_t got, input sys_word_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  //////////////////////////////
  // table building
  //////////////////////////////

  task automatic add_sample(input adc_sample_t a, b, ga, gb, pa, pb);
    table_q.push_back(entry_t'{1'b0, 1'b0, a, b, ga, gb, pa, pb, '0, '0, '0, 1'b0});
  endtask

  task automatic add_bus(input logic wr, input sys_addr_t addr, input sys_word_t wdata,
                         input sys_word_t exp_rdata, input logic exp_err);
    table_q.push_back(entry_t'{1'b1, wr, '0, '0, '0, '0, '0, '0, addr, wdata, exp_rdata,
                               exp_err});
  endtask

  task automatic add_random_sample();
    add_sample(random_sample(), random_sample(), random_sample(),
               random_sample(), random_sample(), random_sample());
  endtask

  //////////////////////////////
  // entry runners start and end on a falling edge
  //////////////////////////////

  task automatic run_sample(input int idx, input entry_t e);
    int err0;
    err0 = errors;
    adc_dat_a_i = e.adc_a;
    adc_dat_b_i = e.adc_b;
    asg_a_i     = e.asg_a;
    asg_b_i     = e.asg_b;
    pid_a_i     = e.pid_a;
    pid_b_i     = e.pid_b;
    @(negedge adc_clk);  // adc register loaded
    if (loop_model)
    begin
      check_sample("adc_ch_a_o", adc_ch_a_o, adc_sample_t'(expect_code(e.asg_a, e.pid_a)));
      check_sample("adc_ch_b_o", adc_ch_b_o, adc_sample_t'(expect_code(e.asg_b, e.pid_b)));
    end
    else
    begin
      check_sample("adc_ch_a_o", adc_ch_a_o, expect_adc(e.adc_b));  // crossed
      check_sample("adc_ch_b_o", adc_ch_b_o, expect_adc(e.adc_a));
    end
    // second dac stage still on the previous samples
    check_code("dac_dat_a_o", dac_dat_a_o, expect_code(last_smp.asg_b, last_smp.pid_b));
    check_code("dac_dat_b_o", dac_dat_b_o, expect_code(last_smp.asg_a, last_smp.pid_a));
    @(negedge adc_clk);  // dac pipe full
    check_code("dac_dat_a_o", dac_dat_a_o, expect_code(e.asg_b, e.pid_b));
    check_code("dac_dat_b_o", dac_dat_b_o, expect_code(e.asg_a, e.pid_a));
    last_smp = e;
    $display("entry %0d sample loop=%0d: %s", idx, loop_model, (errors == err0) ? "pass" : "fail");
  endtask

  task automatic run_bus(input int idx, input entry_t e);
    int err0;
    err0 = errors;
    sys_addr_i  = e.addr;
    sys_wdata_i = e.wdata;
    sys_wen_i   = e.wr;
    sys_ren_i   = ~e.wr;
    // good writes move the register models
    if (e.wr && !e.exp_err && e.addr == sys_addr_t'(`FE_HK_LOOP_OFS))
      loop_model = e.wdata[0];
    if (e.wr && !e.exp_err && e.addr == sys_addr_t'(`FE_HK_LED_OFS))
      led_model = e.wdata[`FE_LED_W-1:0];
    @(negedge adc_clk);
    sys_wen_i = 1'b0;
    sys_ren_i = 1'b0;
    if (sys_ack_o !== 1'b1)
    begin
      errors++;
      $display("entry %0d got no ack one cycle after the bus strobe", idx);
    end
    else
    begin
      check_bit("sys_err_o", sys_err_o, e.exp_err);
      check_word("sys_rdata_o", sys_rdata_o, e.exp_rdata);
    end
    check_word("led_o", sys_word_t'(led_o), sys_word_t'(led_model));
    $display("entry %0d bus %s %h: %s", idx, e.wr ? "wr" : "rd", e.addr,
             (errors == err0) ? "pass" : "fail");
  endtask

  // run limit of four cycles per entry plus reset
  always @(posedge adc_clk)
  begin
    cycles++;
    if (limit > 0 && cycles > limit)
    begin
      $display("run stopped, cycle limit of %0d reached", limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial
  begin
    entry_t e;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    asg_a_i     = '0;
    asg_b_i     = '0;
    pid_a_i     = '0;
    pid_b_i     = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;

    repeat (3) add_random_sample();
    add_sample(random_sample(), random_sample(), 8191, -8192, 100, -1);  // +ovf a, -ovf b
    add_sample(random_sample(), random_sample(), -8192, 8191, -5, 7);    // and swapped
    add_sample(random_sample(), random_sample(), 0, 0, 0, 0);
    add_sample(random_sample(), random_sample(), 4000, -4096, 4191, -4096);  // on the rails
    add_bus(1'b0, sys_addr_t'(`FE_HK_ID_OFS), '0, `FE_HK_ID, 1'b0);
    add_bus(1'b1, sys_addr_t'(`FE_HK_LED_OFS), 32'h0000_00a5, '0, 1'b0);
    add_bus(1'b0, sys_addr_t'(`FE_HK_LED_OFS), '0, 32'h0000_00a5, 1'b0);
    add_bus(1'b1, sys_addr_t'(`FE_HK_LOOP_OFS), 32'h1, '0, 1'b0);
    repeat (2) add_random_sample();
    add_bus(1'b0, sys_addr_t'(`FE_HK_LOOP_OFS), '0, 32'h1, 1'b0);
    add_bus(1'b1, sys_addr_t'(`FE_HK_LOOP_OFS), 32'h0, '0, 1'b0);
    add_random_sample();
    add_bus(1'b0, sys_addr_t'(3 << `FE_REGION_W), '0, '0, 1'b1);           // unmapped rd
    add_bus(1'b1, sys_addr_t'((7 << `FE_REGION_W) | 'h10), 32'hdead, '0, 1'b1);
    add_bus(1'b0, sys_addr_t'('h0c), '0, '0, 1'b1);                        // bad offset
    add_bus(1'b1, sys_addr_t'(`FE_HK_ID_OFS), 32'h1234, '0, 1'b1);        // id is ro
    limit = table_q.size() * 4 + 20;

    // reset held
    @(negedge adc_clk);
    check_bit("dac_reset_o", dac_reset_o, 1'b1);
    wait (reset_i == 1'b0);
    @(negedge adc_clk);
    check_bit("dac_reset_o", dac_reset_o, 1'b0);
    check_bit("sys_ack_o", sys_ack_o, 1'b0);
    check_bit("sys_err_o", sys_err_o, 1'b0);
    check_word("led_o", sys_word_t'(led_o), '0);
    $display("reset: %s", (errors == 0) ? "pass" : "fail");

    for (int i = 0; i < table_q.size(); i++)
    begin
      e = table_q[i];
      if (e.is_bus)
        run_bus(i, e);
      else
        run_sample(i, e);
    end

    $display("%0d entries, %0d checks, %0d errors", table_q.size(), checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule : analog_front_tb

// File: files.f
+incdir+.
sample_pkg.sv
sys_bus_pkg.sv
adc_input_stage.sv
dac_output_stage.sv
sys_bus_decoder.sv
hk_regs.sv
analog_front_top.sv
tb_clock_gen.sv
analog_front_tb.sv

// File: Bender.yml
package:
  name: analog_front_end

export_include_dirs:
  - .

sources:
  - sample_pkg.sv
  - sys_bus_pkg.sv
  - adc_input_stage.sv
  - dac_output_stage.sv
  - sys_bus_decoder.sv
  - hk_regs.sv
  - analog_front_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - analog_front_tb.sv
